/* include/umi_macros.svh */
// UMI routing macros: packet width, command field layout and queue depth
`ifndef UMI_MACROS_SVH
`define UMI_MACROS_SVH

// ##############################
// Packet format
// ##############################

// Full packet width
`define UMI_UW 256

// Command byte sits at the packet LSBs
`define UMI_CMD_W 8

// Command bit set for responses, clear for requests
`define UMI_RESP_BIT 0

// ##############################
// Queue sizing
// ##############################

// Default entries per class queue
`define UMI_QDEPTH 4

`endif

/* src/umi_pkg.sv */
// UMI routing package with packet, command, occupancy and slice state types
`include "umi_macros.svh"

package umi_pkg;

   // ##############################
   // Packet level types
   // ##############################

   // One fixed-width UMI packet
   typedef logic [`UMI_UW-1:0] umi_packet_t;

   // Command field in the low byte
   typedef logic [`UMI_CMD_W-1:0] umi_cmd_t;

   // Occupancy, 0 up to UMI_QDEPTH inclusive
   typedef logic [$clog2(`UMI_QDEPTH+1)-1:0] umi_qcount_t;

   // ##############################
   // Input slice FSM
   // ##############################

   // Entries held in the skid slice
   typedef enum logic [1:0] {
      SLICE_EMPTY = 2'd0,
      SLICE_ONE   = 2'd1,
      SLICE_TWO   = 2'd2
   } slice_state_t;

endpackage

/* src/umi_in_slice.sv */
// UMI input skid slice: two-entry buffer that registers the input handshake
`timescale 1ns/1ps
`include "umi_macros.svh"

module umi_in_slice (
   input  logic                 clk,
   input  logic                 reset,
   // Upstream side
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   // Downstream side
   output logic                 out_valid,
   output umi_pkg::umi_packet_t out_packet,
   input  logic                 out_ready
);

   import umi_pkg::*;

   // ##############################
   // Storage and state
   // ##############################

   // Head entry, always the one presented downstream
   umi_packet_t  main_q;
   // Overflow entry, catches the packet in flight on a stall
   umi_packet_t  skid_q;

   slice_state_t state_q;
   slice_state_t state_d;

   logic         in_fire;
   logic         out_fire;

   // Handshake events
   assign in_fire  = in_valid & in_ready;
   assign out_fire = out_valid & out_ready;

   // Ready purely from state flops
   // Still open with one entry held, skid absorbs the next beat
   assign in_ready  = (state_q != SLICE_TWO);
   assign out_valid = (state_q != SLICE_EMPTY);
   assign out_packet = main_q;

   // ##############################
   // Next state
   // ##############################

   always_comb begin
      state_d = state_q;
      case (state_q)
         SLICE_EMPTY: begin
            if (in_fire) begin
               state_d = SLICE_ONE;
            end
         end
         SLICE_ONE: begin
            // Pass through at full rate, stays in ONE
            if (in_fire && !out_fire) begin
               state_d = SLICE_TWO;
            end else if (!in_fire && out_fire) begin
               state_d = SLICE_EMPTY;
            end
         end
         SLICE_TWO: begin
            // Input closed here, only drain
            if (out_fire) begin
               state_d = SLICE_ONE;
            end
         end
         default: begin
            state_d = SLICE_EMPTY;
         end
      endcase
   end

   // Control state
   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= SLICE_EMPTY;
      end else begin
         state_q <= state_d;
      end
   end

   // ##############################
   // Payload registers
   // ##############################

   always_ff @(posedge clk) begin
      case (state_q)
         SLICE_EMPTY: begin
            if (in_fire) begin
               main_q <= in_packet;
            end
         end
         SLICE_ONE: begin
            // Head leaves, new beat takes its place
            if (in_fire && out_fire) begin
               main_q <= in_packet;
            end else if (in_fire) begin
               skid_q <= in_packet;
            end
         end
         SLICE_TWO: begin
            // Skid entry moves up behind the departing head
            if (out_fire) begin
               main_q <= skid_q;
            end
         end
         default: begin
            main_q <= main_q;
         end
      endcase
   end

endmodule

/* src/umi_splitter.sv */
// UMI traffic splitter: steers each packet to the response or request output
`timescale 1ns/1ps
`include "umi_macros.svh"

module umi_splitter (
   // Input from slice
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   // Response class output
   output logic                 resp_valid,
   output umi_pkg::umi_packet_t resp_packet,
   input  logic                 resp_ready,
   // Request class output
   output logic                 req_valid,
   output umi_pkg::umi_packet_t req_packet,
   input  logic                 req_ready
);

   import umi_pkg::*;

   umi_cmd_t cmd;
   logic     is_resp;

   // Command byte from packet LSBs
   assign cmd     = in_packet[`UMI_CMD_W-1:0];
   assign is_resp = cmd[`UMI_RESP_BIT];

   // Class select, one valid at a time
   assign resp_valid = in_valid & is_resp;
   assign req_valid  = in_valid & ~is_resp;

   // Same payload to both sides
   assign resp_packet = in_packet;
   assign req_packet  = in_packet;

   // Blocking ready
   // Any offered output that is stalled holds the input
   assign in_ready = ~(resp_valid & ~resp_ready) &
                     ~(req_valid & ~req_ready);

endmodule

/* src/umi_queue.sv */
// UMI class queue: synchronous packet FIFO with valid/ready on both sides
`timescale 1ns/1ps
`include "umi_macros.svh"

module umi_queue #(
   parameter int DEPTH = `UMI_QDEPTH
) (
   input  logic                 clk,
   input  logic                 reset,
   // Write side
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   // Read side
   output logic                 out_valid,
   output umi_pkg::umi_packet_t out_packet,
   input  logic                 out_ready
);

   import umi_pkg::*;

   // Pointer width, at least one bit
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // ##############################
   // Storage and pointers
   // ##############################

   umi_packet_t      mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   umi_qcount_t      count;

   logic             wr_en;
   logic             rd_en;

   // Flags from the occupancy register only
   assign in_ready  = (count != umi_qcount_t'(DEPTH));
   assign out_valid = (count != '0);

   assign wr_en = in_valid & in_ready;
   assign rd_en = out_valid & out_ready;

   // Head of queue, one cycle after write
   assign out_packet = mem[rd_ptr];

   // ##############################
   // Control
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Wrap explicitly, depth need not be a power of two
         if (wr_en) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (rd_en) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         // Occupancy, unchanged on read plus write
         case ({wr_en, rd_en})
            2'b10:   count <= count + umi_qcount_t'(1);
            2'b01:   count <= count - umi_qcount_t'(1);
            default: count <= count;
         endcase
      end
   end

   // ##############################
   // Data array
   // ##############################

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_packet;
      end
   end

endmodule

/* src/umi_split_top.sv */
// UMI routing subsystem top: input slice, class splitter and two class queues
`timescale 1ns/1ps
`include "umi_macros.svh"

module umi_split_top (
   input  logic                 clk,
   input  logic                 reset,
   // Packet input
   input  logic                 umi_in_valid,
   input  umi_pkg::umi_packet_t umi_in_packet,
   output logic                 umi_in_ready,
   // Response class output
   output logic                 umi_resp_out_valid,
   output umi_pkg::umi_packet_t umi_resp_out_packet,
   input  logic                 umi_resp_out_ready,
   // Request class output
   output logic                 umi_req_out_valid,
   output umi_pkg::umi_packet_t umi_req_out_packet,
   input  logic                 umi_req_out_ready
);

   import umi_pkg::*;

   // Slice to splitter
   logic        slice_valid;
   umi_packet_t slice_packet;
   logic        slice_ready;

   // Splitter to response queue
   logic        split_resp_valid;
   umi_packet_t split_resp_packet;
   logic        split_resp_ready;

   // Splitter to request queue
   logic        split_req_valid;
   umi_packet_t split_req_packet;
   logic        split_req_ready;

   // ##############################
   // Stage 1, input skid slice
   // ##############################

   umi_in_slice u_slice (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (umi_in_valid),
      .in_packet  (umi_in_packet),
      .in_ready   (umi_in_ready),
      .out_valid  (slice_valid),
      .out_packet (slice_packet),
      .out_ready  (slice_ready)
   );

   // ##############################
   // Stage 2, class splitter
   // ##############################

   umi_splitter u_split (
      .in_valid    (slice_valid),
      .in_packet   (slice_packet),
      .in_ready    (slice_ready),
      .resp_valid  (split_resp_valid),
      .resp_packet (split_resp_packet),
      .resp_ready  (split_resp_ready),
      .req_valid   (split_req_valid),
      .req_packet  (split_req_packet),
      .req_ready   (split_req_ready)
   );

   // ##############################
   // Stage 3, per-class queues
   // ##############################

   umi_queue #(.DEPTH(`UMI_QDEPTH)) u_resp_q (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (split_resp_valid),
      .in_packet  (split_resp_packet),
      .in_ready   (split_resp_ready),
      .out_valid  (umi_resp_out_valid),
      .out_packet (umi_resp_out_packet),
      .out_ready  (umi_resp_out_ready)
   );

   umi_queue #(.DEPTH(`UMI_QDEPTH)) u_req_q (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (split_req_valid),
      .in_packet  (split_req_packet),
      .in_ready   (split_req_ready),
      .out_valid  (umi_req_out_valid),
      .out_packet (umi_req_out_packet),
      .out_ready  (umi_req_out_ready)
   );

endmodule

/* tests/umi_split_chk.sv */
// UMI routing checker: handshake, routing, reset and latency assertions on the top level
`timescale 1ns/1ps
`include "umi_macros.svh"

module umi_split_chk (
   input logic                 clk,
   input logic                 reset,
   input logic                 umi_in_valid,
   input umi_pkg::umi_packet_t umi_in_packet,
   input logic                 umi_in_ready,
   input logic                 umi_resp_out_valid,
   input umi_pkg::umi_packet_t umi_resp_out_packet,
   input logic                 umi_resp_out_ready,
   input logic                 umi_req_out_valid,
   input umi_pkg::umi_packet_t umi_req_out_packet,
   input logic                 umi_req_out_ready,
   input logic                 slice_valid
);

   import umi_pkg::*;

   // Failed assertions so far, read by the testbench
   int unsigned error_count = 0;

   logic in_fire;
   logic idle_open;

   assign in_fire = umi_in_valid & umi_in_ready;
   // Nothing held anywhere, both outputs accepting
   assign idle_open = !slice_valid && !umi_resp_out_valid && !umi_req_out_valid &&
                      umi_resp_out_ready && umi_req_out_ready;

   // ##############################
   // Reset and routing
   // ##############################

   a_reset_state: assert property (@(posedge clk)
      reset |=> (umi_in_ready && !umi_resp_out_valid && !umi_req_out_valid))
      else begin $error("outputs not idle after reset"); error_count++; end

   a_resp_class: assert property (@(posedge clk) disable iff (reset)
      umi_resp_out_valid |-> umi_resp_out_packet[`UMI_RESP_BIT])
      else begin $error("request packet on response output"); error_count++; end

   a_req_class: assert property (@(posedge clk) disable iff (reset)
      umi_req_out_valid |-> !umi_req_out_packet[`UMI_RESP_BIT])
      else begin $error("response packet on request output"); error_count++; end

   // ##############################
   // Handshake stability
   // ##############################

   a_in_hold: assert property (@(posedge clk) disable iff (reset)
      (umi_in_valid && !umi_in_ready) |=> (umi_in_valid && $stable(umi_in_packet)))
      else begin $error("input dropped or changed while stalled"); error_count++; end

   a_resp_hold: assert property (@(posedge clk) disable iff (reset)
      (umi_resp_out_valid && !umi_resp_out_ready) |=>
         (umi_resp_out_valid && $stable(umi_resp_out_packet)))
      else begin $error("response output unstable while stalled"); error_count++; end

   a_req_hold: assert property (@(posedge clk) disable iff (reset)
      (umi_req_out_valid && !umi_req_out_ready) |=>
         (umi_req_out_valid && $stable(umi_req_out_packet)))
      else begin $error("request output unstable while stalled"); error_count++; end

   // ##############################
   // Empty pipeline latency
   // ##############################

   a_resp_latency: assert property (@(posedge clk) disable iff (reset)
      (in_fire && idle_open && umi_in_packet[`UMI_RESP_BIT]) |->
         ##1 !umi_resp_out_valid
         ##1 (umi_resp_out_valid && umi_resp_out_packet == $past(umi_in_packet, 2)))
      else begin $error("response latency not two cycles"); error_count++; end

   a_req_latency: assert property (@(posedge clk) disable iff (reset)
      (in_fire && idle_open && !umi_in_packet[`UMI_RESP_BIT]) |->
         ##1 !umi_req_out_valid
         ##1 (umi_req_out_valid && umi_req_out_packet == $past(umi_in_packet, 2)))
      else begin $error("request latency not two cycles"); error_count++; end

endmodule

/* tests/umi_split_tb.sv */
// UMI routing testbench driving random class traffic and output stalls into a scoreboard
`timescale 1ns/1ps
`include "umi_macros.svh"

module umi_split_tb;

   import umi_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int N_ISOLATED = 8;
   localparam int N_RANDOM = 300;
   localparam int N_STALLED = 24;
   localparam int N_PACKETS = N_ISOLATED + N_RANDOM + N_STALLED;
   localparam int WATCHDOG_CYCLES = N_PACKETS * 8 + 200;
   localparam int MAX_HELD = 2 + 2 * `UMI_QDEPTH;

   // Output ready patterns
   localparam int READY_OPEN = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_STALL = 2;

   logic        clk;
   logic        reset;
   logic        umi_in_valid;
   umi_packet_t umi_in_packet;
   logic        umi_in_ready;
   logic        umi_resp_out_valid;
   umi_packet_t umi_resp_out_packet;
   logic        umi_resp_out_ready;
   logic        umi_req_out_valid;
   umi_packet_t umi_req_out_packet;
   logic        umi_req_out_ready;

   // Expected packets per class with the oldest first
   umi_packet_t exp_resp[$];
   umi_packet_t exp_req[$];

   logic [31:0] lfsr_q = 32'hac171231;
   int          ready_mode = READY_OPEN;
   int          stall_left = 0;
   bit          saw_in_ready_low = 0;

   umi_split_top uut (.*);

   bind umi_split_top umi_split_chk u_chk (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ##############################
   // Helpers
   // ##############################

   task automatic stop_on_failure(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   // Galois form with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
      return r;
   endfunction

   function automatic umi_packet_t random_packet();
      umi_packet_t pkt;
      for (int w = 0; w < `UMI_UW / 32; w++) begin
         pkt[w*32 +: 32] = take_bits(32);
      end
      return pkt;
   endfunction

   // Output readies for the coming cycle
   task automatic drive_readies();
      case (ready_mode)
         READY_RANDOM: begin
            // Ready about three cycles in four
            umi_resp_out_ready = (take_bits(2) != 0);
            umi_req_out_ready  = (take_bits(2) != 0);
         end
         READY_STALL: begin
            umi_resp_out_ready = (stall_left == 0);
            umi_req_out_ready  = 1'b1;
            if (stall_left > 0) begin
               stall_left--;
            end
         end
         default: begin
            umi_resp_out_ready = 1'b1;
            umi_req_out_ready  = 1'b1;
         end
      endcase
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
      drive_readies();
   endtask

   task automatic idle_cycles(input int n);
      umi_in_valid = 1'b0;
      repeat (n) next_cycle();
   endtask

   // Holds valid until the slice takes the packet, then logs it as expected
   task automatic send_packet(input logic resp_cls);
      umi_packet_t pkt;
      pkt = random_packet();
      pkt[`UMI_RESP_BIT] = resp_cls;
      umi_in_packet = pkt;
      umi_in_valid  = 1'b1;
      while (!umi_in_ready) begin
         next_cycle();
      end
      if (resp_cls) begin
         exp_resp.push_back(pkt);
      end else begin
         exp_req.push_back(pkt);
      end
      next_cycle();
      umi_in_valid = 1'b0;
   endtask

   // ##############################
   // Output monitor
   // ##############################

   // Mid-cycle view of the transfers taken at the coming edge
   always @(negedge clk) begin
      if (!reset) begin
         if (uut.u_chk.error_count != 0) begin
            stop_on_failure("a protocol or routing assertion in the checker failed");
         end
         if (umi_resp_out_valid && umi_resp_out_ready) begin
            if (exp_resp.size() == 0) begin
               stop_on_failure("response packet delivered with nothing outstanding");
            end
            assert (umi_resp_out_packet == exp_resp[0]) else
               stop_on_failure($sformatf("mismatch at %0d ns: response packet %h, expected %h",
                                         $time, umi_resp_out_packet, exp_resp[0]));
            void'(exp_resp.pop_front());
         end
         if (umi_req_out_valid && umi_req_out_ready) begin
            if (exp_req.size() == 0) begin
               stop_on_failure("request packet delivered with nothing outstanding");
            end
            assert (umi_req_out_packet == exp_req[0]) else
               stop_on_failure($sformatf("mismatch at %0d ns: request packet %h, expected %h",
                                         $time, umi_req_out_packet, exp_req[0]));
            void'(exp_req.pop_front());
         end
         // Accepted but not yet delivered
         assert (exp_resp.size() + exp_req.size() <= MAX_HELD) else
            stop_on_failure($sformatf("mismatch at %0d ns: %0d packets held, limit %0d",
                                      $time, exp_resp.size() + exp_req.size(), MAX_HELD));
         if (ready_mode == READY_STALL && stall_left > 0 && !umi_in_ready) begin
            saw_in_ready_low = 1'b1;
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stop_on_failure($sformatf("timeout, run not finished after %0d clock periods",
                                WATCHDOG_CYCLES));
   end

   // ##############################
   // Stimulus
   // ##############################

   initial begin
      reset = 1'b1;
      umi_in_valid = 1'b0;
      umi_in_packet = '0;
      umi_resp_out_ready = 1'b1;
      umi_req_out_ready = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;

      // Single packets into an empty pipeline
      ready_mode = READY_OPEN;
      for (int i = 0; i < N_ISOLATED; i++) begin
         send_packet(i[0]);
         idle_cycles(4);
      end

      // Random classes with input gaps and output stalls
      ready_mode = READY_RANDOM;
      for (int i = 0; i < N_RANDOM; i++) begin
         send_packet(take_bits(1) != 0);
         if (take_bits(2) == 0) begin
            idle_cycles(1);
         end
      end

      // Response output stuck low while mixed traffic keeps coming
      stall_left = 40;
      ready_mode = READY_STALL;
      for (int i = 0; i < N_STALLED; i++) begin
         send_packet(i[0]);
      end
      assert (saw_in_ready_low) else
         stop_on_failure("input ready never fell while the response output was stalled");

      // Drain everything still held
      ready_mode = READY_OPEN;
      while (exp_resp.size() != 0 || exp_req.size() != 0) begin
         next_cycle();
      end
      idle_cycles(4);

      if (uut.u_chk.error_count == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         stop_on_failure("checker assertions failed during the run");
      end
   end

endmodule

/* list.f */
+incdir+include
src/umi_pkg.sv
src/umi_in_slice.sv
src/umi_splitter.sv
src/umi_queue.sv
src/umi_split_top.sv
tests/umi_split_chk.sv
tests/umi_split_tb.sv

/* Bender.yml */
package:
  name: umi_split

sources:
  - include_dirs:
      - include
    files:
      - src/umi_pkg.sv
      - src/umi_in_slice.sv
      - src/umi_splitter.sv
      - src/umi_queue.sv
      - src/umi_split_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/umi_split_chk.sv
      - tests/umi_split_tb.sv
